// ==== noc_merge.f ====
logic/noc_merge_pkg.sv
logic/noc_rr_arbiter.sv
logic/noc_merge_cfg.sv
logic/noc_vc_merger.sv
logic/noc_merge_top.sv
tb/noc_merge_sva.sv
tb/noc_merge_tb.sv

// ==== Bender.yml ====
package:
  name: noc_merge

sources:
  # RTL in compile order
  - logic/noc_merge_pkg.sv
  - logic/noc_rr_arbiter.sv
  - logic/noc_merge_cfg.sv
  - logic/noc_vc_merger.sv
  - logic/noc_merge_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - tb/noc_merge_sva.sv
      - tb/noc_merge_tb.sv

// ==== tb/noc_merge_tb.sv ====
`timescale 1ns/1ps

module noc_merge_tb;
  import noc_merge_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY  = 2;

  // Threshold expected after reset
  localparam logic [NOC_TIMEOUT_WIDTH-1:0] RESET_TIMEOUT = 8'd16;

  // Cycle budgets of the tests, summed up for the watchdog
  localparam int BUDGET_RESET  = 24;
  localparam int BUDGET_PASS   = 60;
  localparam int BUDGET_RR     = 120;
  localparam int BUDGET_BP     = 80;
  localparam int BUDGET_ESC    = 120;
  localparam int BUDGET_CFG    = 130;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + BUDGET_RESET + BUDGET_PASS + BUDGET_RR
                                 + BUDGET_BP + BUDGET_ESC + BUDGET_CFG + 100;

  logic                          clk;
  logic                          rst_n;
  logic [NOC_CHANNELS-1:0]       in_valid;
  logic [NOC_FLIT_VEC_WIDTH-1:0] in_flit;
  logic [NOC_CHANNELS-1:0]       in_ready;
  logic [NOC_CHANNELS-1:0]       out_valid;
  logic [NOC_FLIT_WIDTH-1:0]     out_flit;
  logic [NOC_CHANNELS-1:0]       out_ready;
  logic                          cfg_we;
  logic [NOC_TIMEOUT_WIDTH-1:0]  cfg_timeout;
  logic [NOC_TIMEOUT_WIDTH-1:0]  cfg_timeout_out;

  // Flits waiting to be offered, and flits accepted but not yet delivered
  logic [NOC_FLIT_WIDTH-1:0] src_q [NOC_CHANNELS][$];
  logic [NOC_FLIT_WIDTH-1:0] exp_q [NOC_CHANNELS][$];
  int                        exp_cyc_q [NOC_CHANNELS][$];
  int                        delivered [NOC_CHANNELS];
  int                        skip_cnt [NOC_CHANNELS];
  int                        cycle_cnt = 0;
  bit                        check_latency = 1'b0;
  bit                        check_fair = 1'b0;
  string                     test_name = "init";

  noc_merge_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid),
    .in_flit_i     (in_flit),
    .in_ready_o    (in_ready),
    .out_valid_o   (out_valid),
    .out_flit_o    (out_flit),
    .out_ready_i   (out_ready),
    .cfg_we_i      (cfg_we),
    .cfg_timeout_i (cfg_timeout),
    .cfg_timeout_o (cfg_timeout_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
               test_name, what, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic start_test(string name);
    test_name = name;
    for (int c = 0; c < NOC_CHANNELS; c++) begin
      delivered[c] = 0;
      skip_cnt[c]  = 0;
    end
  endtask

  task automatic queue_flits(int ch, int count);
    repeat (count) begin
      src_q[ch].push_back($urandom());
    end
  endtask

  function automatic int pending_flits();
    int total;
    total = 0;
    for (int c = 0; c < NOC_CHANNELS; c++) begin
      total += src_q[c].size() + exp_q[c].size();
    end
    return total;
  endfunction

  // Head of each source queue is offered shortly after the edge
  always @(posedge clk) begin
    #(DRIVE_DELAY);
    for (int c = 0; c < NOC_CHANNELS; c++) begin
      if (src_q[c].size() != 0) begin
        in_valid[c] = 1'b1;
        in_flit[c*NOC_FLIT_WIDTH +: NOC_FLIT_WIDTH] = src_q[c][0];
      end else begin
        in_valid[c] = 1'b0;
      end
    end
  end

  task automatic record_delivery(int ch);
    logic [NOC_FLIT_WIDTH-1:0] expected;
    int                        accepted_at;
    if (exp_q[ch].size() == 0) begin
      $display("Channel %0d delivered flit 0x%0h that was never accepted in test %s",
               ch, out_flit, test_name);
      end_with_failure();
    end else begin
      expected    = exp_q[ch].pop_front();
      accepted_at = exp_cyc_q[ch].pop_front();
      check_value($sformatf("ch%0d flit", ch), expected, out_flit);
      if (check_latency) begin
        check_value($sformatf("ch%0d latency", ch), 1, cycle_cnt - accepted_at);
      end
      delivered[ch]++;
      // A waiting channel may see at most one grant of each other channel
      for (int c = 0; c < NOC_CHANNELS; c++) begin
        if (c == ch) begin
          skip_cnt[c] = 0;
        end else if (in_valid[c]) begin
          skip_cnt[c]++;
          if (check_fair) begin
            check_value($sformatf("ch%0d waited a full round", c), 1,
                        skip_cnt[c] < NOC_CHANNELS);
          end
        end
      end
    end
  endtask

  // Handshakes are sampled mid-cycle, where all inputs and outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      for (int c = 0; c < NOC_CHANNELS; c++) begin
        if (in_valid[c] && in_ready[c]) begin
          exp_q[c].push_back(in_flit[c*NOC_FLIT_WIDTH +: NOC_FLIT_WIDTH]);
          exp_cyc_q[c].push_back(cycle_cnt);
          void'(src_q[c].pop_front());
        end
      end
      for (int c = 0; c < NOC_CHANNELS; c++) begin
        if (out_valid[c] && out_ready[c]) begin
          record_delivery(c);
        end
      end
    end
  end

  task automatic wait_drain(int max_cycles);
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (pending_flits() != 0 && n < max_cycles);
    if (pending_flits() != 0) begin
      $display("Test %s: %0d flits still pending after %0d cycles",
               test_name, pending_flits(), max_cycles);
      end_with_failure();
    end
  endtask

  task automatic wait_channel_empty(int ch, int max_cycles);
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while ((src_q[ch].size() + exp_q[ch].size()) != 0 && n < max_cycles);
    if ((src_q[ch].size() + exp_q[ch].size()) != 0) begin
      $display("Test %s: channel %0d not drained after %0d cycles", test_name, ch, max_cycles);
      end_with_failure();
    end
  endtask

  task automatic wait_for_valid(int ch, int max_cycles);
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!out_valid[ch] && n < max_cycles);
    if (!out_valid[ch]) begin
      $display("Test %s: no flit of channel %0d on the output within %0d cycles",
               test_name, ch, max_cycles);
      end_with_failure();
    end
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    check_value("out_valid", 0, out_valid);
    check_value("in_ready", 0, in_ready);
    check_value("threshold", RESET_TIMEOUT, cfg_timeout_out);
  endtask

  task automatic test_pass_through();
    start_test("pass_through");
    out_ready     = '1;
    check_latency = 1'b1;
    queue_flits(2, 8);
    wait_drain(BUDGET_PASS);
    check_value("ch2 deliveries", 8, delivered[2]);
    check_latency = 1'b0;
  endtask

  task automatic test_round_robin();
    start_test("round_robin");
    out_ready  = '1;
    check_fair = 1'b1;
    for (int c = 0; c < NOC_CHANNELS; c++) begin
      queue_flits(c, 6);
    end
    wait_drain(BUDGET_RR);
    for (int c = 0; c < NOC_CHANNELS; c++) begin
      check_value($sformatf("ch%0d deliveries", c), 6, delivered[c]);
    end
    check_fair = 1'b0;
  endtask

  task automatic test_back_pressure();
    logic [NOC_FLIT_WIDTH-1:0] held;
    start_test("back_pressure");
    out_ready = '1;
    queue_flits(3, 2);
    queue_flits(1, 3);
    wait_for_valid(3, 20);
    out_ready[3] = 1'b0;
    held         = out_flit;
    // Stall well below the threshold
    repeat (RESET_TIMEOUT - 6) begin
      next_cycle();
      check_value("held valid", 4'b1000, out_valid);
      check_value("held flit", held, out_flit);
    end
    out_ready[3] = 1'b1;
    wait_drain(BUDGET_BP);
    check_value("ch3 deliveries", 2, delivered[3]);
    check_value("ch1 deliveries", 3, delivered[1]);
  endtask

  task automatic test_timeout_escape(string name, int limit);
    start_test(name);
    out_ready = '1;
    queue_flits(0, 2);
    wait_for_valid(0, 20);
    out_ready[0] = 1'b0;
    queue_flits(1, 4);
    // Channel 1 only gets through once the held flit is released
    wait_for_valid(1, limit + 4);
    wait_channel_empty(1, 40);
    check_value("ch1 deliveries", 4, delivered[1]);
    next_cycle();
    out_ready[0] = 1'b1;
    // Replay of the parked flit must not take a new input flit
    @(negedge clk);
    check_value("ch0 in_ready on replay", 0, in_ready[0]);
    wait_drain(BUDGET_ESC);
    check_value("ch0 deliveries", 2, delivered[0]);
  endtask

  task automatic test_config();
    start_test("config_write");
    cfg_timeout = 8'd4;
    cfg_we      = 1'b1;
    next_cycle();
    cfg_we = 1'b0;
    check_value("threshold readback", 4, cfg_timeout_out);
    test_timeout_escape("config_escape", 4);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired: run not finished after %0d cycles", WATCHDOG_CYCLES);
    end_with_failure();
  end

  initial begin
    void'($urandom(86993));
    rst_n       = 1'b0;
    in_valid    = '0;
    in_flit     = '0;
    out_ready   = '0;
    cfg_we      = 1'b0;
    cfg_timeout = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    test_reset_state();
    test_pass_through();
    test_round_robin();
    test_back_pressure();
    test_timeout_escape("timeout_escape", RESET_TIMEOUT);
    test_config();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tb/noc_merge_sva.sv ====
`timescale 1ns/1ps

module noc_merge_sva (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]   out_valid_i,
  input  logic [noc_merge_pkg::NOC_FLIT_WIDTH-1:0] out_flit_i,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]   out_ready_i,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]   in_ready_i,
  input  logic                                     timeout_i
);

  // At most one channel owns the output register
  a_out_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(out_valid_i)
  ) else $error("out_valid_o is neither one-hot nor zero");

  // Held flit must not move until consumed or released by timeout
  a_out_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      (out_valid_i != '0) && ((out_valid_i & out_ready_i) == '0) && !timeout_i
      |=> $stable(out_valid_i) && $stable(out_flit_i)
  ) else $error("Held output flit changed while waiting for ready");

  // Input side only opens for the channel that wins the output register
  a_ready_granted: assert property (
    @(posedge clk) disable iff (!rst_n)
      (in_ready_i != '0) |=> (out_valid_i == $past(in_ready_i))
  ) else $error("in_ready_o raised on a channel that did not win the output");

endmodule

bind noc_vc_merger noc_merge_sva u_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .out_valid_i (out_valid_o),
  .out_flit_i  (out_flit_o),
  .out_ready_i (out_ready_i),
  .in_ready_i  (in_ready_o),
  .timeout_i   (timeout)
);

// ==== logic/noc_merge_top.sv ====
`timescale 1ns/1ps

module noc_merge_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]       in_valid_i,
  input  logic [noc_merge_pkg::NOC_FLIT_VEC_WIDTH-1:0] in_flit_i,
  output logic [noc_merge_pkg::NOC_CHANNELS-1:0]       in_ready_o,
  output logic [noc_merge_pkg::NOC_CHANNELS-1:0]       out_valid_o,
  output logic [noc_merge_pkg::NOC_FLIT_WIDTH-1:0]     out_flit_o,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]       out_ready_i,
  input  logic                                         cfg_we_i,
  input  logic [noc_merge_pkg::NOC_TIMEOUT_WIDTH-1:0]  cfg_timeout_i,
  output logic [noc_merge_pkg::NOC_TIMEOUT_WIDTH-1:0]  cfg_timeout_o
);
  import noc_merge_pkg::*;

  logic [NOC_CHANNELS-1:0] request;
  logic [NOC_CHANNELS-1:0] grant;

  // Threshold register, also feeds the merger
  noc_merge_cfg u_cfg (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_we_i      (cfg_we_i),
    .cfg_timeout_i (cfg_timeout_i),
    .cfg_timeout_o (cfg_timeout_o)
  );

  noc_vc_merger u_merger (
    .clk             (clk),
    .rst_n           (rst_n),
    .timeout_limit_i (cfg_timeout_o),
    .in_valid_i      (in_valid_i),
    .in_flit_i       (in_flit_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_flit_o      (out_flit_o),
    .out_ready_i     (out_ready_i),
    .request_o       (request),
    .grant_i         (grant)
  );

  // Grant comes back in the same cycle as the request
  noc_rr_arbiter u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .request_i (request),
    .grant_o   (grant)
  );

endmodule

// ==== logic/noc_vc_merger.sv ====
`timescale 1ns/1ps

module noc_vc_merger (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [noc_merge_pkg::NOC_TIMEOUT_WIDTH-1:0]  timeout_limit_i,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]       in_valid_i,
  input  logic [noc_merge_pkg::NOC_FLIT_VEC_WIDTH-1:0] in_flit_i,
  output logic [noc_merge_pkg::NOC_CHANNELS-1:0]       in_ready_o,
  output logic [noc_merge_pkg::NOC_CHANNELS-1:0]       out_valid_o,
  output logic [noc_merge_pkg::NOC_FLIT_WIDTH-1:0]     out_flit_o,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]       out_ready_i,
  output logic [noc_merge_pkg::NOC_CHANNELS-1:0]       request_o,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0]       grant_i
);
  import noc_merge_pkg::*;

  // Per-channel escape state
  logic [NOC_CHANNELS-1:0]      parked;
  logic [NOC_CHANNELS-1:0]      stalled;
  logic [NOC_CHANNELS-1:0]      escaped;
  logic [NOC_FLIT_WIDTH-1:0]    esc_buf   [NOC_CHANNELS];
  logic [NOC_FLIT_WIDTH-1:0]    cand_flit [NOC_CHANNELS];

  // Output side
  logic [NOC_FLIT_WIDTH-1:0]    sel_flit;
  logic                         out_load;
  logic                         out_busy;
  logic                         out_taken;
  logic                         grant_any;

  // Timeout tracking for the held flit
  logic [NOC_TIMEOUT_WIDTH-1:0] timeout_cnt;
  logic                         timeout;

  assign out_busy  = (out_valid_o != '0);
  assign out_taken = ((out_valid_o & out_ready_i) != '0);
  assign grant_any = (grant_i != '0);

  // Output register can take a new flit this cycle
  assign out_load = !out_busy || out_taken || timeout;

  for (genvar c = 0; c < NOC_CHANNELS; c++) begin : g_channel

    // Held flit of this channel is being released without delivery
    assign stalled[c] = timeout && out_valid_o[c] && !out_ready_i[c];

    // Escape buffer replaces the input while the channel is parked
    assign escaped[c] = parked[c] || stalled[c];

    assign cand_flit[c] = escaped[c] ? esc_buf[c]
                                     : in_flit_i[c*NOC_FLIT_WIDTH +: NOC_FLIT_WIDTH];

    // Only compete when downstream of this channel can take a flit
    assign request_o[c] = (in_valid_i[c] || escaped[c]) && out_load && out_ready_i[c];

    // Input is not accepted while a parked flit is waiting for replay
    assign in_ready_o[c] = grant_i[c] && !escaped[c];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        parked[c] <= 1'b0;
      end else if (grant_i[c]) begin
        parked[c] <= 1'b0;
      end else if (stalled[c]) begin
        parked[c] <= 1'b1;
      end
    end

    // Keeps a copy of the last granted flit for replay after a timeout
    always_ff @(posedge clk) begin
      if (grant_i[c]) begin
        esc_buf[c] <= cand_flit[c];
      end
    end

  end

  // One-hot AND-OR multiplexer on the grant
  always_comb begin
    sel_flit = '0;
    for (int c = 0; c < NOC_CHANNELS; c++) begin
      sel_flit = sel_flit | ({NOC_FLIT_WIDTH{grant_i[c]}} & cand_flit[c]);
    end
  end

  // Valid bits name the channel of the held flit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= '0;
    end else if (out_load) begin
      out_valid_o <= grant_i;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load && grant_any) begin
      out_flit_o <= sel_flit;
    end
  end

  // Fires once the held flit has waited the configured number of cycles
  assign timeout = out_busy && (timeout_cnt >= timeout_limit_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timeout_cnt <= '0;
    end else if (!out_busy || grant_any || timeout) begin
      timeout_cnt <= '0;
    end else begin
      timeout_cnt <= timeout_cnt + 1'b1;
    end
  end

endmodule

// ==== logic/noc_merge_cfg.sv ====
`timescale 1ns/1ps

module noc_merge_cfg (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        cfg_we_i,
  input  logic [noc_merge_pkg::NOC_TIMEOUT_WIDTH-1:0] cfg_timeout_i,
  output logic [noc_merge_pkg::NOC_TIMEOUT_WIDTH-1:0] cfg_timeout_o
);
  import noc_merge_pkg::*;

  logic [NOC_TIMEOUT_WIDTH-1:0] timeout_q;

  // Threshold register, written by a single-cycle strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timeout_q <= NOC_TIMEOUT_DEFAULT;
    end else if (cfg_we_i) begin
      timeout_q <= cfg_timeout_i;
    end
  end

  // Readback and merger both see the stored value
  assign cfg_timeout_o = timeout_q;

endmodule

// ==== logic/noc_rr_arbiter.sv ====
`timescale 1ns/1ps

module noc_rr_arbiter (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [noc_merge_pkg::NOC_CHANNELS-1:0] request_i,
  output logic [noc_merge_pkg::NOC_CHANNELS-1:0] grant_o
);
  import noc_merge_pkg::*;

  // Channel with the highest priority in the current cycle
  logic [NOC_CHANNEL_IDX_WIDTH-1:0] prio_ptr;
  logic [NOC_CHANNEL_IDX_WIDTH-1:0] winner;
  logic                             grant_valid;

  // Scan from the pointer upward and wrap, first requester wins
  always_comb begin : grant_search
    int unsigned idx;
    logic        found;

    grant_o = '0;
    winner  = prio_ptr;
    found   = 1'b0;
    for (int unsigned i = 0; i < NOC_CHANNELS; i++) begin
      idx = (int'(prio_ptr) + i) % NOC_CHANNELS;
      if (!found && request_i[idx]) begin
        grant_o[idx] = 1'b1;
        winner       = NOC_CHANNEL_IDX_WIDTH'(idx);
        found        = 1'b1;
      end
    end
  end

  assign grant_valid = (grant_o != '0);

  // Winner drops to lowest priority on the next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_ptr <= '0;
    end else if (grant_valid) begin
      if (winner == NOC_CHANNEL_IDX_WIDTH'(NOC_CHANNELS - 1)) begin
        prio_ptr <= '0;
      end else begin
        prio_ptr <= winner + 1'b1;
      end
    end
  end

endmodule

// ==== logic/noc_merge_pkg.sv ====
package noc_merge_pkg;

  // Number of virtual channels merged onto the link
  localparam int unsigned NOC_CHANNELS = 4;

  // Width of the pointer that selects one channel
  localparam int unsigned NOC_CHANNEL_IDX_WIDTH = $clog2(NOC_CHANNELS);

  // A flit is an opaque word here
  localparam int unsigned NOC_FLIT_WIDTH = 32;

  // Width of the flit vector carrying all channels side by side
  localparam int unsigned NOC_FLIT_VEC_WIDTH = NOC_CHANNELS * NOC_FLIT_WIDTH;

  // Timeout threshold and counter width
  localparam int unsigned NOC_TIMEOUT_WIDTH = 8;

  // Threshold loaded at reset, in cycles
  localparam logic [NOC_TIMEOUT_WIDTH-1:0] NOC_TIMEOUT_DEFAULT = 8'd16;

endpackage
